/* hw/l1d_pkg.sv */
package l1d_pkg;

    // Cache geometry
    localparam int TAG_W     = 8;
    localparam int INDEX_W   = 9;
    localparam int WADDR_W   = TAG_W + INDEX_W;
    localparam int DATA_W    = 32;
    localparam int BE_W      = DATA_W / 8;
    localparam int NUM_LINES = 1 << INDEX_W;

    // Word address split into tag and line index
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } l1d_addr_fields_t;

    // Flat word address for memory, tag and index for the cache
    typedef union packed {
        logic [WADDR_W-1:0] word;
        l1d_addr_fields_t   f;
    } l1d_addr_u;

    // Processor load/store request, byte enables of zero mean a read
    typedef struct packed {
        logic              sel;
        l1d_addr_u         addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } cpu_req_t;

    // Memory request, strobe of zero means a read
    typedef struct packed {
        logic               valid;
        logic [WADDR_W-1:0] addr;
        logic [DATA_W-1:0]  wdata;
        logic [BE_W-1:0]    wstrb;
    } mem_req_t;

    typedef struct packed {
        logic               en;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        logic [DATA_W-1:0]  data;
        logic [BE_W-1:0]    be;
    } ram_wr_t;

    typedef struct packed {
        logic               en;
        logic [INDEX_W-1:0] index;
        logic               valid;
        logic               dirty;
    } line_upd_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL_WRITE,
        MEM_READ,
        MEM_WRITE,
        DONE
    } l1d_state_e;

endpackage

/* hw/l1d_tag_data_ram.sv */
`timescale 1ns/1ps

module l1d_tag_data_ram (
    input  logic                         clk_i,
    input  l1d_pkg::ram_wr_t             wr_i,
    input  logic [l1d_pkg::INDEX_W-1:0]  rd_index_i,
    output logic [l1d_pkg::TAG_W-1:0]    rd_tag_o,
    output logic [l1d_pkg::DATA_W-1:0]   rd_data_o
);
    import l1d_pkg::*;

    // One tag and one data word per line, data kept as byte lanes
    logic [TAG_W-1:0]         tag_mem  [NUM_LINES];
    logic [BE_W-1:0][7:0]     data_mem [NUM_LINES];
    logic                     any_byte;

    assign any_byte = |wr_i.be;

    // Write port
    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wr_i.be[b]) begin
                    data_mem[wr_i.index][b] <= wr_i.data[8*b +: 8];
                end
            end
            // Tag follows any written byte
            if (any_byte) begin
                tag_mem[wr_i.index] <= wr_i.tag;
            end
        end
    end

    // Registered read port, old contents on a same-cycle write
    always_ff @(posedge clk_i) begin
        rd_tag_o  <= tag_mem[rd_index_i];
        rd_data_o <= data_mem[rd_index_i];
    end

endmodule

/* hw/l1d_line_state.sv */
`timescale 1ns/1ps

module l1d_line_state (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [l1d_pkg::INDEX_W-1:0] lookup_index_i,
    output logic                        valid_o,
    output logic                        dirty_o,
    input  l1d_pkg::line_upd_t          upd_i
);
    import l1d_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;

    // One line updated per cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (upd_i.en) begin
            valid_q[upd_i.index] <= upd_i.valid;
            dirty_q[upd_i.index] <= upd_i.dirty;
        end
    end

    // Combinational lookup for the request cycle
    assign valid_o = valid_q[lookup_index_i];
    assign dirty_o = dirty_q[lookup_index_i];

endmodule

/* hw/l1d_controller.sv */
`timescale 1ns/1ps

module l1d_controller (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Processor port
    input  l1d_pkg::cpu_req_t           cpu_req_i,
    output logic [l1d_pkg::DATA_W-1:0]  rdata_o,
    output logic                        stall_o,
    // Memory port
    output l1d_pkg::mem_req_t           mem_req_o,
    input  logic [l1d_pkg::DATA_W-1:0]  mem_rdata_i,
    input  logic                        mem_ready_i,
    // Tag/data RAM
    output l1d_pkg::ram_wr_t            ram_wr_o,
    output logic [l1d_pkg::INDEX_W-1:0] ram_rd_index_o,
    input  logic [l1d_pkg::TAG_W-1:0]   ram_tag_i,
    input  logic [l1d_pkg::DATA_W-1:0]  ram_data_i,
    // Line-state array
    input  logic                        line_valid_i,
    input  logic                        line_dirty_i,
    output l1d_pkg::line_upd_t          line_upd_o
);
    import l1d_pkg::*;

    l1d_state_e        state_q;
    l1d_state_e        state_d;
    mem_req_t          mem_q;
    logic [DATA_W-1:0] fill_word_q;
    logic              filled_q;

    logic              is_write;
    logic              is_full;
    logic              tag_hit;
    logic              dirty_line;
    logic              mem_done;
    l1d_addr_u         victim_addr;
    logic [DATA_W-1:0] merged_word;

    assign is_write   = |cpu_req_i.be;
    assign is_full    = &cpu_req_i.be;
    assign tag_hit    = (ram_tag_i == cpu_req_i.addr.f.tag);
    assign dirty_line = line_valid_i && line_dirty_i;
    assign mem_done   = mem_q.valid && mem_ready_i;

    // Request is held stable, so the RAM always reads its line
    assign ram_rd_index_o = cpu_req_i.addr.f.index;

    // Write-back address rebuilt from the stored tag
    always_comb begin
        victim_addr.f.tag   = ram_tag_i;
        victim_addr.f.index = cpu_req_i.addr.f.index;
    end

    // Processor bytes over the fetched word, any mask pattern
    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            if (cpu_req_i.be[b]) begin
                merged_word[8*b +: 8] = cpu_req_i.wdata[8*b +: 8];
            end else begin
                merged_word[8*b +: 8] = mem_rdata_i[8*b +: 8];
            end
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cpu_req_i.sel) begin
                    // Full word over a clean or empty line needs no tag check
                    if (is_full && !dirty_line) begin
                        state_d = FILL_WRITE;
                    end else if (!line_valid_i) begin
                        state_d = MEM_READ;
                    end else begin
                        state_d = LOOKUP;
                    end
                end
            end

            LOOKUP: begin
                if (filled_q) begin
                    state_d = DONE;
                end else if (tag_hit) begin
                    state_d = is_write ? FILL_WRITE : DONE;
                end else if (line_dirty_i) begin
                    state_d = MEM_WRITE;
                end else begin
                    state_d = MEM_READ;
                end
            end

            MEM_WRITE: begin
                if (mem_ready_i) begin
                    // A full word replaces the line without a fetch
                    state_d = is_full ? FILL_WRITE : MEM_READ;
                end
            end

            MEM_READ: begin
                if (mem_ready_i) begin
                    state_d = FILL_WRITE;
                end
            end

            FILL_WRITE: begin
                // Reads pick up the filled word in LOOKUP
                state_d = is_write ? DONE : LOOKUP;
            end

            DONE: begin
                state_d = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Stall rises with the request and falls in DONE
    assign stall_o = (state_q == IDLE) ? cpu_req_i.sel : (state_q != DONE);

    // RAM write, fetched lines go in whole
    always_comb begin
        ram_wr_o.en    = (state_q == FILL_WRITE);
        ram_wr_o.index = cpu_req_i.addr.f.index;
        ram_wr_o.tag   = cpu_req_i.addr.f.tag;
        ram_wr_o.data  = filled_q ? fill_word_q : cpu_req_i.wdata;
        ram_wr_o.be    = filled_q ? {BE_W{1'b1}} : cpu_req_i.be;
    end

    // Line becomes valid, dirty only for stores
    always_comb begin
        line_upd_o.en    = (state_q == FILL_WRITE);
        line_upd_o.index = cpu_req_i.addr.f.index;
        line_upd_o.valid = 1'b1;
        line_upd_o.dirty = is_write;
    end

    assign mem_req_o = mem_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= IDLE;
            filled_q    <= 1'b0;
            mem_q.valid <= 1'b0;
            mem_q.wstrb <= '0;
        end else begin
            state_q <= state_d;

            if (state_q == MEM_READ && mem_ready_i) begin
                filled_q <= 1'b1;
            end else if (state_q == DONE) begin
                filled_q <= 1'b0;
            end

            // Victim write-back, then a read can follow back to back
            if (state_d == MEM_WRITE && state_q != MEM_WRITE) begin
                mem_q.valid <= 1'b1;
                mem_q.addr  <= victim_addr.word;
                mem_q.wdata <= ram_data_i;
                mem_q.wstrb <= {BE_W{1'b1}};
            end else if (state_d == MEM_READ && state_q != MEM_READ) begin
                mem_q.valid <= 1'b1;
                mem_q.addr  <= cpu_req_i.addr.word;
                mem_q.wstrb <= '0;
            end else if (mem_done) begin
                mem_q.valid <= 1'b0;
            end
        end
    end

    // Fetched word merged once on arrival
    always_ff @(posedge clk_i) begin
        if (state_q == MEM_READ && mem_ready_i) begin
            fill_word_q <= merged_word;
        end
    end

    // Load data captured when leaving LOOKUP
    always_ff @(posedge clk_i) begin
        if (state_q == LOOKUP && state_d == DONE) begin
            rdata_o <= filled_q ? fill_word_q : ram_data_i;
        end
    end

endmodule

/* hw/l1d_top.sv */
`timescale 1ns/1ps

module l1d_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  l1d_pkg::cpu_req_t          cpu_req_i,
    output logic [l1d_pkg::DATA_W-1:0] rdata_o,
    output logic                       stall_o,
    output l1d_pkg::mem_req_t          mem_req_o,
    input  logic [l1d_pkg::DATA_W-1:0] mem_rdata_i,
    input  logic                       mem_ready_i
);
    import l1d_pkg::*;

    ram_wr_t            ram_wr;
    logic [INDEX_W-1:0] ram_rd_index;
    logic [TAG_W-1:0]   ram_tag;
    logic [DATA_W-1:0]  ram_data;
    logic               line_valid;
    logic               line_dirty;
    line_upd_t          line_upd;

    l1d_controller u_controller (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cpu_req_i      (cpu_req_i),
        .rdata_o        (rdata_o),
        .stall_o        (stall_o),
        .mem_req_o      (mem_req_o),
        .mem_rdata_i    (mem_rdata_i),
        .mem_ready_i    (mem_ready_i),
        .ram_wr_o       (ram_wr),
        .ram_rd_index_o (ram_rd_index),
        .ram_tag_i      (ram_tag),
        .ram_data_i     (ram_data),
        .line_valid_i   (line_valid),
        .line_dirty_i   (line_dirty),
        .line_upd_o     (line_upd)
    );

    // Valid and dirty looked up for the request's line
    l1d_line_state u_line_state (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_index_i (cpu_req_i.addr.f.index),
        .valid_o        (line_valid),
        .dirty_o        (line_dirty),
        .upd_i          (line_upd)
    );

    l1d_tag_data_ram u_tag_data_ram (
        .clk_i      (clk_i),
        .wr_i       (ram_wr),
        .rd_index_i (ram_rd_index),
        .rd_tag_o   (ram_tag),
        .rd_data_o  (ram_data)
    );

endmodule

/* testbench/l1d_props.sv */
`timescale 1ns/1ps

module l1d_props (
    input logic                clk_i,
    input logic                rst_i,
    input logic                stall_i,
    input l1d_pkg::l1d_state_e state_i,
    input l1d_pkg::mem_req_t   mem_req_i,
    input logic                mem_ready_i
);
    import l1d_pkg::*;

    // Request held until the memory takes it
    assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_i.valid && !mem_ready_i) |=> $stable(mem_req_i))
        else $error("memory request changed while waiting for ready");

    // Write-backs carry a full strobe, fetches none
    assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_i.valid |-> ((state_i == MEM_WRITE) ? (mem_req_i.wstrb == '1)
                                                    : (mem_req_i.wstrb == '0)))
        else $error("memory strobe does not match the transfer type");

    assert property (@(posedge clk_i)
        rst_i |=> (!stall_i && !mem_req_i.valid))
        else $error("stall or memory valid high right after reset");

endmodule

bind l1d_controller l1d_props u_props (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall_o),
    .state_i     (state_q),
    .mem_req_i   (mem_req_o),
    .mem_ready_i (mem_ready_i)
);

/* testbench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  l1d_pkg::mem_req_t          mem_req_i,
    output logic [l1d_pkg::DATA_W-1:0] mem_rdata_o,
    output logic                       mem_ready_o,
    output int                         rd_count_o,
    output int                         wr_count_o,
    output l1d_pkg::mem_req_t          last_wr_o,
    output l1d_pkg::mem_req_t          last_xfer_o
);
    import l1d_pkg::*;

    logic [DATA_W-1:0] mem [logic [WADDR_W-1:0]];
    logic [31:0]       lfsr_q;
    logic              pending;
    logic [1:0]        wait_cnt;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Untouched words follow a pattern of the whole address
    function automatic logic [DATA_W-1:0] fill_word(input logic [WADDR_W-1:0] a);
        return 32'ha500_0000 ^ {a, 15'h0} ^ {15'h0, a};
    endfunction

    function automatic logic [DATA_W-1:0] read_word(input logic [WADDR_W-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    always @(posedge clk_i) begin
        logic [DATA_W-1:0] word;
        logic              fire;
        if (rst_i) begin
            mem_ready_o <= 1'b0;
            mem_rdata_o <= '0;
            rd_count_o  <= 0;
            wr_count_o  <= 0;
            last_wr_o   <= '0;
            last_xfer_o <= '0;
            lfsr_q      = 32'h5096_794f;
            pending     = 1'b0;
            wait_cnt    = 2'd0;
        end else begin
            mem_ready_o <= 1'b0;
            fire = 1'b0;
            if (mem_req_i.valid && !mem_ready_o) begin
                // Delay of 0 to 3 cycles from two LFSR bits
                if (!pending) begin
                    lfsr_q = lfsr_step(lfsr_q);
                    wait_cnt[0] = lfsr_q[0];
                    lfsr_q = lfsr_step(lfsr_q);
                    wait_cnt[1] = lfsr_q[0];
                    pending = 1'b1;
                end
                if (wait_cnt == 2'd0) begin
                    fire = 1'b1;
                    pending = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
            if (fire) begin
                mem_ready_o <= 1'b1;
                word = read_word(mem_req_i.addr);
                if (mem_req_i.wstrb != '0) begin
                    for (int b = 0; b < BE_W; b++) begin
                        if (mem_req_i.wstrb[b]) begin
                            word[8*b +: 8] = mem_req_i.wdata[8*b +: 8];
                        end
                    end
                    mem[mem_req_i.addr] = word;
                    wr_count_o  <= wr_count_o + 1;
                    last_wr_o   <= mem_req_i;
                    last_xfer_o <= mem_req_i;
                end else begin
                    mem_rdata_o <= word;
                    rd_count_o  <= rd_count_o + 1;
                    // Write data is meaningless on a read
                    last_xfer_o <= '{valid: 1'b1, addr: mem_req_i.addr, wdata: '0, wstrb: '0};
                end
            end
        end
    end

endmodule

/* testbench/tb_l1d.sv */
`timescale 1ns/1ps

module tb_l1d;
    import l1d_pkg::*;

    localparam int TIMEOUT = 200;

    logic              clk;
    logic              rst;
    cpu_req_t          cpu_req;
    logic [DATA_W-1:0] rdata;
    logic              stall;
    mem_req_t          mem_req;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_ready;
    int                rd_count;
    int                wr_count;
    mem_req_t          last_wr;
    mem_req_t          last_xfer;
    logic [31:0]       lfsr;
    logic [DATA_W-1:0] shadow [logic [WADDR_W-1:0]];

    l1d_top DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .cpu_req_i   (cpu_req),
        .rdata_o     (rdata),
        .stall_o     (stall),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    tb_mem_model u_mem (
        .clk_i       (clk),
        .rst_i       (rst),
        .mem_req_i   (mem_req),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready),
        .rd_count_o  (rd_count),
        .wr_count_o  (wr_count),
        .last_wr_o   (last_wr),
        .last_xfer_o (last_xfer)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic l1d_addr_u mk_addr(input logic [TAG_W-1:0] tag,
                                          input logic [INDEX_W-1:0] index);
        l1d_addr_u a;
        a.f.tag   = tag;
        a.f.index = index;
        return a;
    endfunction

    function automatic cpu_req_t make_req(input l1d_addr_u a, input logic [DATA_W-1:0] wdata,
                                          input logic [BE_W-1:0] be);
        return '{sel: 1'b1, addr: a, wdata: wdata, be: be};
    endfunction

    // Memory as the processor should see it
    function automatic logic [DATA_W-1:0] expected_word(input logic [WADDR_W-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return 32'ha500_0000 ^ {a, 15'h0} ^ {15'h0, a};
    endfunction

    task automatic access(input cpu_req_t req, output logic [DATA_W-1:0] got,
                          output int stall_cycles);
        logic [DATA_W-1:0] word;
        @(posedge clk);
        cpu_req <= req;
        stall_cycles = 0;
        @(negedge clk);
        while (stall) begin
            stall_cycles++;
            if (stall_cycles > TIMEOUT) begin
                $display("timeout: stall_o never fell for address %h", req.addr.word);
                stop_on_error();
            end
            @(negedge clk);
        end
        got = rdata;
        @(posedge clk);
        cpu_req <= '0;
        if (req.be != '0) begin
            word = expected_word(req.addr.word);
            for (int b = 0; b < BE_W; b++) begin
                if (req.be[b]) begin
                    word[8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
            shadow[req.addr.word] = word;
        end
    endtask

    task automatic test_read_miss();
        l1d_addr_u a;
        logic [DATA_W-1:0] got;
        int cyc;
        int rd0;
        int wr0;
        a = mk_addr(8'h03, 9'h005);
        rd0 = rd_count;
        wr0 = wr_count;
        access(make_req(a, '0, 4'h0), got, cyc);
        check_word("rdata_o", got, expected_word(a.word));
        check_count("memory reads", rd_count - rd0, 1);
        check_count("memory writes", wr_count - wr0, 0);
    endtask

    task automatic test_read_hit();
        l1d_addr_u a;
        logic [DATA_W-1:0] got;
        int cyc;
        int rd0;
        int wr0;
        a = mk_addr(8'h03, 9'h005);
        rd0 = rd_count;
        wr0 = wr_count;
        access(make_req(a, '0, 4'h0), got, cyc);
        check_word("rdata_o", got, expected_word(a.word));
        check_count("stall_o cycles", cyc, 2);
        check_count("memory reads", rd_count - rd0, 0);
        check_count("memory writes", wr_count - wr0, 0);
    endtask

    task automatic test_full_write();
        l1d_addr_u a;
        logic [DATA_W-1:0] got;
        int cyc;
        int rd0;
        a = mk_addr(8'h07, 9'h014);
        rd0 = rd_count;
        access(make_req(a, 32'hdead_beef, 4'hf), got, cyc);
        check_count("stall_o cycles", cyc, 2);
        access(make_req(a, '0, 4'h0), got, cyc);
        check_word("rdata_o", got, 32'hdead_beef);
        check_count("memory reads", rd_count - rd0, 0);
        check_count("memory writes", wr_count, 0);
    endtask

    task automatic test_partial_write();
        logic [BE_W-1:0] masks [5];
        l1d_addr_u a;
        logic [DATA_W-1:0] got;
        int cyc;
        int rd0;
        masks = '{4'b0001, 4'b0110, 4'b1010, 4'b0111, 4'b1000};
        for (int i = 0; i < 5; i++) begin
            a = mk_addr(8'h09, 9'(48 + i));
            rd0 = rd_count;
            access(make_req(a, 32'h1122_3344 + i, masks[i]), got, cyc);
            check_count("memory reads", rd_count - rd0, 1);
            access(make_req(a, '0, 4'h0), got, cyc);
            check_word("rdata_o", got, expected_word(a.word));
            check_count("memory reads", rd_count - rd0, 1);
        end
    endtask

    task automatic test_dirty_evict();
        l1d_addr_u old_a;
        l1d_addr_u new_a;
        logic [DATA_W-1:0] got;
        int cyc;
        int rd0;
        int wr0;
        old_a = mk_addr(8'h07, 9'h014);
        new_a = mk_addr(8'h08, 9'h014);
        rd0 = rd_count;
        wr0 = wr_count;
        access(make_req(new_a, '0, 4'h0), got, cyc);
        check_word("rdata_o", got, expected_word(new_a.word));
        check_count("memory writes", wr_count - wr0, 1);
        check_count("memory reads", rd_count - rd0, 1);
        check_mem_req("mem_req_o write", last_wr,
                      '{valid: 1'b1, addr: old_a.word, wdata: 32'hdead_beef, wstrb: 4'hf});
        // Read must come after the write-back
        check_mem_req("mem_req_o read", last_xfer,
                      '{valid: 1'b1, addr: new_a.word, wdata: '0, wstrb: '0});
    endtask

    task automatic test_random_traffic();
        logic [31:0] tag_r;
        logic [31:0] idx_r;
        logic [31:0] op_r;
        logic [31:0] mask_r;
        logic [31:0] data_r;
        l1d_addr_u a;
        logic [DATA_W-1:0] got;
        int cyc;
        for (int i = 0; i < 60; i++) begin
            rand_bits(2, tag_r);
            rand_bits(2, idx_r);
            rand_bits(2, op_r);
            rand_bits(4, mask_r);
            rand_bits(32, data_r);
            a = mk_addr(8'h10 + 8'(tag_r[1:0]), 9'h040 + 9'(idx_r[1:0]));
            if (op_r[1:0] < 2'd2) begin
                access(make_req(a, '0, 4'h0), got, cyc);
                check_word("rdata_o", got, expected_word(a.word));
            end else if (op_r[1:0] == 2'd2) begin
                access(make_req(a, data_r, 4'hf), got, cyc);
            end else begin
                access(make_req(a, data_r, (mask_r[3:0] == 4'h0) ? 4'b0101 : mask_r[3:0]),
                       got, cyc);
            end
        end
    endtask

    initial begin
        rst     <= 1'b1;
        cpu_req <= '0;
        lfsr    = 32'h5096_794f;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_read_miss();
        test_read_hit();
        test_full_write();
        test_partial_write();
        test_dirty_evict();
        test_random_traffic();
        repeat (2) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* l1d_cache.f */
hw/l1d_pkg.sv
hw/l1d_tag_data_ram.sv
hw/l1d_line_state.sv
hw/l1d_controller.sv
hw/l1d_top.sv
testbench/l1d_props.sv
testbench/tb_mem_model.sv
testbench/tb_l1d.sv

/* Makefile */
# Verilator simulation of the L1 data cache

TOP := tb_l1d

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f l1d_cache.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
